// ==== regPkg.sv ====
`default_nettype none

// Register file geometry shared by the sequencer, the bank and the top
package regPkg;

  // Width of a register number
  localparam int regAddrW = 5;

  // Number of general registers, r0 included
  localparam int regCount = 32;

  // Register and memory word width
  localparam int dataW = 32;

endpackage

`default_nettype wire

// ==== memOpPkg.sv ====
`default_nettype none

package memOpPkg;

  // Operation kinds carried over the host channel
  typedef enum logic [1:0] {
    OpWriteImm = 2'd0,
    OpRead     = 2'd1,
    OpStore    = 2'd2,
    OpLoad     = 2'd3
  } opKindT;

  // Access sizes, encoding 3 is unused and treated as a word
  typedef enum logic [1:0] {
    SizeByte = 2'd0,
    SizeHalf = 2'd1,
    SizeWord = 2'd2
  } accSizeT;

  // Data RAM depth in words
  localparam int ramDepth = 16;

  // Word index, taken from address bits 5:2
  localparam int ramAddrW = 4;

  // One enable per byte lane
  localparam int laneW = 4;

endpackage

`default_nettype wire

// ==== opIntake.sv ====
`timescale 1ns/1ps
`default_nettype none

module opIntake (
  input  logic                        gclk,
  input  logic                        rstN,
  input  logic                        opReq,
  input  memOpPkg::opKindT            opKind,
  input  memOpPkg::accSizeT           opSize,
  input  logic [regPkg::regAddrW-1:0] opRd,
  input  logic [regPkg::regAddrW-1:0] opRa,
  input  logic [regPkg::regAddrW-1:0] opRb,
  input  logic [regPkg::dataW-1:0]    opImm,
  input  logic                        busy,
  output logic                        opAck,
  output logic                        opStart,
  output memOpPkg::opKindT            stKind,
  output memOpPkg::accSizeT           stSize,
  output logic [regPkg::regAddrW-1:0] stRd,
  output logic [regPkg::regAddrW-1:0] stRa,
  output logic [regPkg::regAddrW-1:0] stRb,
  output logic [regPkg::dataW-1:0]    stImm
);

  typedef enum logic [1:0] {
    InIdle,
    InAcked,
    InWaitLow
  } inStateT;

  inStateT state;
  logic    accept;

  // Take a new operation only while the sequencer is free
  assign accept = (state == InIdle) && opReq && !busy;

  always_ff @(posedge gclk) begin
    if (!rstN) begin
      state <= InIdle;
    end else begin
      case (state)
        InIdle: begin
          if (accept) begin
            state <= InAcked;
          end
        end
        InAcked: begin
          state <= InWaitLow;
        end
        default: begin
          if (!opReq) begin
            state <= InIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge gclk) begin
    if (accept) begin
      stKind <= opKind;
      stSize <= opSize;
      stRd   <= opRd;
      stRa   <= opRa;
      stRb   <= opRb;
      stImm  <= opImm;
    end
  end

  // Ack stays up until the host drops its request
  assign opAck   = (state != InIdle);
  assign opStart = (state == InAcked);

endmodule

`default_nettype wire

// ==== laneSizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module laneSizer (
  input  memOpPkg::accSizeT          size,
  input  logic [1:0]                 addrLow,
  input  logic [regPkg::dataW-1:0]   storeIn,
  input  logic [regPkg::dataW-1:0]   loadIn,
  output logic [regPkg::dataW-1:0]   laneData,
  output logic [memOpPkg::laneW-1:0] laneEn,
  output logic                       misaligned,
  output logic [regPkg::dataW-1:0]   loadOut
);

  import memOpPkg::*;

  // Store side: replicate and pick lanes
  always_comb begin
    case (size)
      SizeByte: begin
        laneData   = {4{storeIn[7:0]}};
        laneEn     = 4'b0001 << addrLow;
        misaligned = 1'b0;
      end
      SizeHalf: begin
        laneData   = {2{storeIn[15:0]}};
        laneEn     = addrLow[1] ? 4'b1100 : 4'b0011;
        misaligned = addrLow[0];
      end
      default: begin
        laneData   = storeIn;
        laneEn     = 4'b1111;
        misaligned = (addrLow != 2'b00);
      end
    endcase
  end

  // Load side, zero extended
  always_comb begin
    case (size)
      SizeByte: begin
        case (addrLow)
          2'd0:    loadOut = {24'd0, loadIn[7:0]};
          2'd1:    loadOut = {24'd0, loadIn[15:8]};
          2'd2:    loadOut = {24'd0, loadIn[23:16]};
          default: loadOut = {24'd0, loadIn[31:24]};
        endcase
      end
      SizeHalf: begin
        loadOut = addrLow[1] ? {16'd0, loadIn[31:16]} : {16'd0, loadIn[15:0]};
      end
      default: loadOut = loadIn;
    endcase
  end

endmodule

`default_nettype wire

// ==== regBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module regBank (
  input  logic                        gclk,
  input  logic [regPkg::regAddrW-1:0] rdAddrA,
  input  logic [regPkg::regAddrW-1:0] rdAddrB,
  output logic [regPkg::dataW-1:0]    rdDataA,
  output logic [regPkg::dataW-1:0]    rdDataB,
  input  logic                        wrEn,
  input  logic [regPkg::regAddrW-1:0] wrAddr,
  input  logic [regPkg::dataW-1:0]    wrData
);

  import regPkg::*;

  logic [dataW-1:0] regs [regCount];

  // Writes to r0 are dropped
  always_ff @(posedge gclk) begin
    if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Registered reads, r0 forced to zero
  always_ff @(posedge gclk) begin
    rdDataA <= (rdAddrA == '0) ? '0 : regs[rdAddrA];
    rdDataB <= (rdAddrB == '0) ? '0 : regs[rdAddrB];
  end

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataRam (
  input  logic                          gclk,
  input  logic [memOpPkg::ramAddrW-1:0] ramAddr,
  input  logic [memOpPkg::laneW-1:0]    ramWe,
  input  logic [regPkg::dataW-1:0]      ramWData,
  output logic [regPkg::dataW-1:0]      ramRData
);

  import regPkg::*;
  import memOpPkg::*;

  logic [dataW-1:0] mem [ramDepth];

  always_ff @(posedge gclk) begin
    // Each enable covers one byte lane
    for (int i = 0; i < laneW; i++) begin
      if (ramWe[i]) begin
        mem[ramAddr][i*8 +: 8] <= ramWData[i*8 +: 8];
      end
    end
    ramRData <= mem[ramAddr];
  end

endmodule

`default_nettype wire

// ==== resultSender.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultSender (
  input  logic                     gclk,
  input  logic                     rstN,
  input  logic                     sendStart,
  input  logic [regPkg::dataW-1:0] sendData,
  input  logic                     sendFault,
  output logic                     sendBusy,
  output logic                     rspReq,
  output logic [regPkg::dataW-1:0] rspData,
  output logic                     rspFault,
  input  logic                     rspAck
);

  typedef enum logic [1:0] {
    SndIdle,
    SndReq,
    SndAckLow
  } sndStateT;

  sndStateT state;

  always_ff @(posedge gclk) begin
    if (!rstN) begin
      state <= SndIdle;
    end else begin
      case (state)
        SndIdle: begin
          if (sendStart) begin
            state <= SndReq;
          end
        end
        SndReq: begin
          if (rspAck) begin
            state <= SndAckLow;
          end
        end
        default: begin
          // Wait for the host to finish the return-to-zero half
          if (!rspAck) begin
            state <= SndIdle;
          end
        end
      endcase
    end
  end

  // Response held steady through the whole handshake
  always_ff @(posedge gclk) begin
    if (sendStart && state == SndIdle) begin
      rspData  <= sendData;
      rspFault <= sendFault;
    end
  end

  assign rspReq   = (state == SndReq);
  assign sendBusy = (state != SndIdle);

endmodule

`default_nettype wire

// ==== opSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module opSequencer (
  input  logic                         gclk,
  input  logic                         rstN,
  input  logic                         opStart,
  input  memOpPkg::opKindT             stKind,
  input  memOpPkg::accSizeT            stSize,
  input  logic [regPkg::regAddrW-1:0]  stRd,
  input  logic [regPkg::regAddrW-1:0]  stRa,
  input  logic [regPkg::regAddrW-1:0]  stRb,
  input  logic [regPkg::dataW-1:0]     stImm,
  output logic                         busy,
  output logic [regPkg::regAddrW-1:0]  rdAddrA,
  output logic [regPkg::regAddrW-1:0]  rdAddrB,
  input  logic [regPkg::dataW-1:0]     rdDataA,
  input  logic [regPkg::dataW-1:0]     rdDataB,
  output logic                         wrEn,
  output logic [regPkg::regAddrW-1:0]  wrAddr,
  output logic [regPkg::dataW-1:0]     wrData,
  output logic [1:0]                   szAddrLow,
  output memOpPkg::accSizeT            szSize,
  output logic [regPkg::dataW-1:0]     szStoreIn,
  input  logic [regPkg::dataW-1:0]     szLaneData,
  input  logic [memOpPkg::laneW-1:0]   szLaneEn,
  input  logic                         szMisaligned,
  output logic [regPkg::dataW-1:0]     szLoadIn,
  input  logic [regPkg::dataW-1:0]     szLoadOut,
  output logic [memOpPkg::ramAddrW-1:0] ramAddr,
  output logic [memOpPkg::laneW-1:0]   ramWe,
  output logic [regPkg::dataW-1:0]     ramWData,
  input  logic [regPkg::dataW-1:0]     ramRData,
  output logic                         sendStart,
  output logic [regPkg::dataW-1:0]     sendData,
  output logic                         sendFault,
  input  logic                         sendBusy
);

  import regPkg::*;
  import memOpPkg::*;

  typedef enum logic [2:0] {
    SeqIdle,
    SeqRead,
    SeqAddr,
    SeqAccess,
    SeqWriteback,
    SeqRespond
  } seqStateT;

  seqStateT         state;
  logic [dataW-1:0] addrReg;
  logic [dataW-1:0] storeVal;
  logic [dataW-1:0] resultReg;
  logic             isMem;
  logic             fault;

  // Fixed four cycles from opStart to sendStart
  always_ff @(posedge gclk) begin
    if (!rstN) begin
      state <= SeqIdle;
    end else begin
      case (state)
        SeqIdle: begin
          if (opStart) begin
            state <= SeqRead;
          end
        end
        SeqRead:      state <= SeqAddr;
        SeqAddr:      state <= SeqAccess;
        SeqAccess:    state <= SeqWriteback;
        SeqWriteback: state <= SeqRespond;
        default: begin
          // Hold until the sender has finished its handshake
          if (!sendBusy) begin
            state <= SeqIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge gclk) begin
    if (state == SeqAddr) begin
      addrReg  <= rdDataA + stImm;
      storeVal <= rdDataB;
    end
    if (state == SeqAccess) begin
      case (stKind)
        OpWriteImm: resultReg <= (stRd == '0) ? '0 : stImm;
        OpRead:     resultReg <= rdDataA;
        OpStore:    resultReg <= storeVal;
        default:    resultReg <= '0;
      endcase
    end
  end

  assign busy = opStart || (state != SeqIdle);

  // Operand fields stay put for the whole operation
  assign rdAddrA = stRa;
  assign rdAddrB = stRb;

  assign szSize    = stSize;
  assign szAddrLow = addrReg[1:0];
  assign szStoreIn = storeVal;
  assign szLoadIn  = ramRData;

  assign ramAddr  = addrReg[ramAddrW+1:2];
  assign ramWData = szLaneData;
  assign ramWe    = (state == SeqAccess && stKind == OpStore && !szMisaligned) ?
                    szLaneEn : '0;

  assign isMem = (stKind == OpStore) || (stKind == OpLoad);
  assign fault = isMem && szMisaligned;

  // Loads and immediates write back, faults never do
  assign wrEn   = (state == SeqWriteback) && !fault &&
                  (stKind == OpWriteImm || stKind == OpLoad);
  assign wrAddr = stRd;
  assign wrData = (stKind == OpLoad) ? szLoadOut : stImm;

  assign sendStart = (state == SeqWriteback);
  assign sendFault = fault;
  assign sendData  = fault ? '0 : ((stKind == OpLoad) ? szLoadOut : resultReg);

endmodule

`default_nettype wire

// ==== lsuRegTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuRegTop (
  input  logic                        gclk,
  input  logic                        rstN,
  input  logic                        opReq,
  output logic                        opAck,
  input  memOpPkg::opKindT            opKind,
  input  memOpPkg::accSizeT           opSize,
  input  logic [regPkg::regAddrW-1:0] opRd,
  input  logic [regPkg::regAddrW-1:0] opRa,
  input  logic [regPkg::regAddrW-1:0] opRb,
  input  logic [regPkg::dataW-1:0]    opImm,
  output logic                        rspReq,
  input  logic                        rspAck,
  output logic [regPkg::dataW-1:0]    rspData,
  output logic                        rspFault
);

  import regPkg::*;
  import memOpPkg::*;

  // Intake to sequencer
  logic                opStart;
  logic                busy;
  opKindT              stKind;
  accSizeT             stSize;
  logic [regAddrW-1:0] stRd;
  logic [regAddrW-1:0] stRa;
  logic [regAddrW-1:0] stRb;
  logic [dataW-1:0]    stImm;

  // Register bank ports
  logic [regAddrW-1:0] rdAddrA;
  logic [regAddrW-1:0] rdAddrB;
  logic [dataW-1:0]    rdDataA;
  logic [dataW-1:0]    rdDataB;
  logic                wrEn;
  logic [regAddrW-1:0] wrAddr;
  logic [dataW-1:0]    wrData;

  // Sizer and RAM
  logic [1:0]          szAddrLow;
  accSizeT             szSize;
  logic [dataW-1:0]    szStoreIn;
  logic [dataW-1:0]    szLaneData;
  logic [laneW-1:0]    szLaneEn;
  logic                szMisaligned;
  logic [dataW-1:0]    szLoadIn;
  logic [dataW-1:0]    szLoadOut;
  logic [ramAddrW-1:0] ramAddr;
  logic [laneW-1:0]    ramWe;
  logic [dataW-1:0]    ramWData;
  logic [dataW-1:0]    ramRData;

  // Sequencer to sender
  logic                sendStart;
  logic [dataW-1:0]    sendData;
  logic                sendFault;
  logic                sendBusy;

  opIntake i_opIntake (
    .gclk(gclk), .rstN(rstN), .opReq(opReq), .opKind(opKind), .opSize(opSize),
    .opRd(opRd), .opRa(opRa), .opRb(opRb), .opImm(opImm), .busy(busy),
    .opAck(opAck), .opStart(opStart), .stKind(stKind), .stSize(stSize),
    .stRd(stRd), .stRa(stRa), .stRb(stRb), .stImm(stImm)
  );

  opSequencer i_opSequencer (
    .gclk(gclk), .rstN(rstN), .opStart(opStart), .stKind(stKind),
    .stSize(stSize), .stRd(stRd), .stRa(stRa), .stRb(stRb), .stImm(stImm),
    .busy(busy), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA),
    .rdDataB(rdDataB), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .szAddrLow(szAddrLow), .szSize(szSize), .szStoreIn(szStoreIn),
    .szLaneData(szLaneData), .szLaneEn(szLaneEn), .szMisaligned(szMisaligned),
    .szLoadIn(szLoadIn), .szLoadOut(szLoadOut), .ramAddr(ramAddr),
    .ramWe(ramWe), .ramWData(ramWData), .ramRData(ramRData),
    .sendStart(sendStart), .sendData(sendData), .sendFault(sendFault),
    .sendBusy(sendBusy)
  );

  regBank i_regBank (
    .gclk(gclk), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA),
    .rdDataB(rdDataB), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  laneSizer i_laneSizer (
    .size(szSize), .addrLow(szAddrLow), .storeIn(szStoreIn), .loadIn(szLoadIn),
    .laneData(szLaneData), .laneEn(szLaneEn), .misaligned(szMisaligned),
    .loadOut(szLoadOut)
  );

  dataRam i_dataRam (
    .gclk(gclk), .ramAddr(ramAddr), .ramWe(ramWe), .ramWData(ramWData),
    .ramRData(ramRData)
  );

  resultSender i_resultSender (
    .gclk(gclk), .rstN(rstN), .sendStart(sendStart), .sendData(sendData),
    .sendFault(sendFault), .sendBusy(sendBusy), .rspReq(rspReq),
    .rspData(rspData), .rspFault(rspFault), .rspAck(rspAck)
  );

endmodule

`default_nettype wire

// ==== lsuRegTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuRegTb;

  import regPkg::*;
  import memOpPkg::*;

  localparam int MaxOps = 48;

  logic                gclk;
  logic                rstN;
  logic                opReq;
  logic                opAck;
  opKindT              opKind;
  accSizeT             opSize;
  logic [regAddrW-1:0] opRd;
  logic [regAddrW-1:0] opRa;
  logic [regAddrW-1:0] opRb;
  logic [dataW-1:0]    opImm;
  logic                rspReq;
  logic                rspAck;
  logic [dataW-1:0]    rspData;
  logic                rspFault;

  // Operation table, one row per host operation
  string               nameTab [MaxOps];
  opKindT              kindTab [MaxOps];
  accSizeT             sizeTab [MaxOps];
  logic [regAddrW-1:0] rdTab [MaxOps];
  logic [regAddrW-1:0] raTab [MaxOps];
  logic [regAddrW-1:0] rbTab [MaxOps];
  logic [dataW-1:0]    immTab [MaxOps];
  logic [dataW-1:0]    expDataTab [MaxOps];
  logic                expFaultTab [MaxOps];
  int                  opCount;

  int                  mismatchErrors;
  int                  protocolErrors;
  int                  cycles;
  int                  timeoutLimit;
  integer              seed;
  string               curName;
  string               waitingFor;
  logic                prevReq;
  logic [dataW-1:0]    heldData;
  logic                heldFault;

  lsuRegTop i_lsuRegTop (
    .gclk(gclk), .rstN(rstN), .opReq(opReq), .opAck(opAck), .opKind(opKind),
    .opSize(opSize), .opRd(opRd), .opRa(opRa), .opRb(opRb), .opImm(opImm),
    .rspReq(rspReq), .rspAck(rspAck), .rspData(rspData), .rspFault(rspFault)
  );

  initial gclk = 1'b0;
  always #5 gclk = ~gclk;

  task automatic addOp(input string name, input opKindT kind, input accSizeT size,
                       input logic [regAddrW-1:0] rd, input logic [regAddrW-1:0] ra,
                       input logic [regAddrW-1:0] rb, input logic [dataW-1:0] imm,
                       input logic [dataW-1:0] expData, input logic expFault);
    nameTab[opCount]     = name;
    kindTab[opCount]     = kind;
    sizeTab[opCount]     = size;
    rdTab[opCount]       = rd;
    raTab[opCount]       = ra;
    rbTab[opCount]       = rb;
    immTab[opCount]      = imm;
    expDataTab[opCount]  = expData;
    expFaultTab[opCount] = expFault;
    opCount++;
  endtask

  // Expected values follow the replication and byte-enable rules by hand
  task automatic buildTable;
    opCount = 0;
    addOp("wrImmR1",       OpWriteImm, SizeWord, 1, 0, 0, 32'h1122_3344, 32'h1122_3344, 0);
    addOp("wrImmR2",       OpWriteImm, SizeWord, 2, 0, 0, 32'hA5A5_F00F, 32'hA5A5_F00F, 0);
    addOp("wrImmR3",       OpWriteImm, SizeWord, 3, 0, 0, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 0);
    addOp("wrImmR0",       OpWriteImm, SizeWord, 0, 0, 0, 32'h1234_5678, 32'h0000_0000, 0);
    addOp("readR1",        OpRead,     SizeWord, 0, 1, 0, 32'h0,         32'h1122_3344, 0);
    addOp("readR2",        OpRead,     SizeWord, 0, 2, 0, 32'h0,         32'hA5A5_F00F, 0);
    addOp("readR3",        OpRead,     SizeWord, 0, 3, 0, 32'h0,         32'hDEAD_BEEF, 0);
    addOp("readR0",        OpRead,     SizeWord, 0, 0, 0, 32'h0,         32'h0000_0000, 0);
    // Word store and load back through r4 as base
    addOp("wrImmR4",       OpWriteImm, SizeWord, 4, 0, 0, 32'h0000_0010, 32'h0000_0010, 0);
    addOp("storeWord10",   OpStore,    SizeWord, 0, 4, 3, 32'h0,         32'hDEAD_BEEF, 0);
    addOp("loadWord10",    OpLoad,     SizeWord, 5, 4, 0, 32'h0,         32'hDEAD_BEEF, 0);
    addOp("readR5",        OpRead,     SizeWord, 0, 5, 0, 32'h0,         32'hDEAD_BEEF, 0);
    // Byte merges into word 0x20
    addOp("wrImmR6",       OpWriteImm, SizeWord, 6, 0, 0, 32'h1234_56AB, 32'h1234_56AB, 0);
    addOp("storeWord20",   OpStore,    SizeWord, 0, 0, 1, 32'h20,        32'h1122_3344, 0);
    addOp("storeByte0",    OpStore,    SizeByte, 0, 0, 6, 32'h20,        32'h1234_56AB, 0);
    addOp("storeByte1",    OpStore,    SizeByte, 0, 0, 3, 32'h21,        32'hDEAD_BEEF, 0);
    addOp("storeByte2",    OpStore,    SizeByte, 0, 0, 2, 32'h22,        32'hA5A5_F00F, 0);
    addOp("storeByte3",    OpStore,    SizeByte, 0, 0, 6, 32'h23,        32'h1234_56AB, 0);
    addOp("loadMerged20",  OpLoad,     SizeWord, 8, 0, 0, 32'h20,        32'hAB0F_EFAB, 0);
    // Halfword merges into word 0x24
    addOp("storeWord24",   OpStore,    SizeWord, 0, 0, 3, 32'h24,        32'hDEAD_BEEF, 0);
    addOp("storeHalf0",    OpStore,    SizeHalf, 0, 0, 1, 32'h24,        32'h1122_3344, 0);
    addOp("storeHalf2",    OpStore,    SizeHalf, 0, 0, 2, 32'h26,        32'hA5A5_F00F, 0);
    addOp("loadMerged24",  OpLoad,     SizeWord, 9, 0, 0, 32'h24,        32'hF00F_3344, 0);
    // Narrow loads, zero extended
    addOp("loadByte0",     OpLoad,     SizeByte, 10, 0, 0, 32'h20,       32'h0000_00AB, 0);
    addOp("loadByte1",     OpLoad,     SizeByte, 10, 0, 0, 32'h21,       32'h0000_00EF, 0);
    addOp("loadByte2",     OpLoad,     SizeByte, 10, 0, 0, 32'h22,       32'h0000_000F, 0);
    addOp("loadByte3",     OpLoad,     SizeByte, 10, 0, 0, 32'h23,       32'h0000_00AB, 0);
    addOp("loadHalf0",     OpLoad,     SizeHalf, 10, 0, 0, 32'h20,       32'h0000_EFAB, 0);
    addOp("loadHalf2",     OpLoad,     SizeHalf, 10, 0, 0, 32'h22,       32'h0000_AB0F, 0);
    addOp("loadHalfHi24",  OpLoad,     SizeHalf, 13, 0, 0, 32'h26,       32'h0000_F00F, 0);
    addOp("readR10",       OpRead,     SizeWord, 0, 10, 0, 32'h0,        32'h0000_AB0F, 0);
    // Misaligned accesses leave memory and r11 alone
    addOp("wrImmR11",      OpWriteImm, SizeWord, 11, 0, 0, 32'h5555_5555, 32'h5555_5555, 0);
    addOp("storeHalfOdd",  OpStore,    SizeHalf, 0, 0, 3, 32'h25,        32'h0000_0000, 1);
    addOp("storeWordOff2", OpStore,    SizeWord, 0, 4, 3, 32'h12,        32'h0000_0000, 1);
    addOp("loadWordOff2",  OpLoad,     SizeWord, 11, 0, 0, 32'h22,       32'h0000_0000, 1);
    addOp("loadHalfOdd",   OpLoad,     SizeHalf, 11, 0, 0, 32'h21,       32'h0000_0000, 1);
    addOp("loadAfter20",   OpLoad,     SizeWord, 12, 0, 0, 32'h20,       32'hAB0F_EFAB, 0);
    addOp("loadAfter24",   OpLoad,     SizeWord, 12, 0, 0, 32'h24,       32'hF00F_3344, 0);
    addOp("readR11",       OpRead,     SizeWord, 0, 11, 0, 32'h0,        32'h5555_5555, 0);
    timeoutLimit = opCount * 30;
  endtask

  // One full operation, request side then response side
  task automatic runOp(input int idx);
    int ackDelay;
    curName = nameTab[idx];
    opKind  = kindTab[idx];
    opSize  = sizeTab[idx];
    opRd    = rdTab[idx];
    opRa    = raTab[idx];
    opRb    = rbTab[idx];
    opImm   = immTab[idx];
    opReq   = 1'b1;
    waitingFor = "opAck to rise";
    @(posedge gclk);
    while (!opAck) @(posedge gclk);
    #1 opReq = 1'b0;
    waitingFor = "opAck to fall";
    @(posedge gclk);
    while (opAck) @(posedge gclk);
    waitingFor = "rspReq to rise";
    while (!rspReq) @(posedge gclk);
    assert (rspData === expDataTab[idx] && rspFault === expFaultTab[idx]) else begin
      mismatchErrors++;
      $display("Mismatch %s: expected %h fault %b, actual %h fault %b", curName,
               expDataTab[idx], expFaultTab[idx], rspData, rspFault);
    end
    // Host is slow to acknowledge by 0 to 5 cycles
    ackDelay = {$random(seed)} % 6;
    repeat (ackDelay) @(posedge gclk);
    #1 rspAck = 1'b1;
    waitingFor = "rspReq to fall";
    @(posedge gclk);
    while (rspReq) @(posedge gclk);
    #1 rspAck = 1'b0;
  endtask

  // Response must hold while rspReq is up
  always @(posedge gclk) begin
    if (rspReq && prevReq) begin
      assert (rspData === heldData && rspFault === heldFault) else begin
        mismatchErrors++;
        $display("Mismatch %s: held response %h/%b, actual %h/%b", curName,
                 heldData, heldFault, rspData, rspFault);
      end
    end
    prevReq   = rspReq;
    heldData  = rspData;
    heldFault = rspFault;
  end

  always @(posedge gclk) begin
    cycles++;
    if (cycles >= timeoutLimit) begin
      $display("Timeout after %0d cycles while waiting for %s in %s", cycles,
               waitingFor, curName);
      $display("Errors: %0d mismatches, %0d protocol", mismatchErrors, protocolErrors);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    seed           = 3055;
    mismatchErrors = 0;
    protocolErrors = 0;
    cycles         = 0;
    prevReq        = 1'b0;
    curName        = "reset";
    waitingFor     = "reset";
    rstN           = 1'b0;
    opReq          = 1'b0;
    opKind         = OpWriteImm;
    opSize         = SizeByte;
    opRd           = '0;
    opRa           = '0;
    opRb           = '0;
    opImm          = '0;
    rspAck         = 1'b0;
    buildTable();
    repeat (3) @(posedge gclk);
    #1 rstN = 1'b1;
    assert (opAck === 1'b0 && rspReq === 1'b0) else begin
      protocolErrors++;
      $display("Handshake outputs are not low after reset");
    end
    for (int i = 0; i < opCount; i++) begin
      runOp(i);
    end
    $display("Errors: %0d mismatches, %0d protocol", mismatchErrors, protocolErrors);
    if (mismatchErrors == 0 && protocolErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
regPkg.sv
memOpPkg.sv
opIntake.sv
laneSizer.sv
regBank.sv
dataRam.sv
resultSender.sv
opSequencer.sv
lsuRegTop.sv
lsuRegTb.sv
